//--- tb.f
common/cf_pkg.sv
branch_unit/comparator.sv
branch_unit/branch_unit.sv
verilog/instr_decoder.sv
verilog/pc_sequencer.sv
verilog/control_flow_top.sv
tb/control_flow_assertions.sv
tb/control_flow_tb.sv

//--- Makefile
# Verilator simulation of the control-flow subsystem

LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the testbench, then check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -f tb.f --top-module control_flow_tb -Mdir obj_dir
	./obj_dir/Vcontrol_flow_tb | tee $(LOG)
	@if grep -q "^sim passed$$" $(LOG); then \
		echo "Result: pass"; \
	else \
		echo "Result: fail"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

//--- tb/control_flow_tb.sv
// ----------------------------------------
// Control-flow testbench
// Directed tests of branches, jumps, ecall, mret and IRQ entry
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module control_flow_tb;

    import cf_pkg::*;

    localparam int    PERIOD        = 40;
    localparam word_t RESET_ADDRESS = 32'h0000_0100;
    localparam word_t IRQ_ADDRESS   = 32'h0000_0040;
    localparam word_t TRAP_ADDRESS  = 32'h0000_0080;
    // Reset and idle, then one cycle per step of each test
    localparam int    TOTAL_CYCLES  = 3 + 6 + 24 + 6 + 3 + 5 + 2;
    localparam int    MARGIN        = 20;

    bit          clk = 1'b0;
    bit          reset;
    bit          enable;
    bit          irq;
    instr_word_u instr;
    word_t       xs1;
    word_t       xs2;
    word_t       pc;
    word_t       pc_next;

    logic [15:0] lfsr_state;
    word_t       m_pc;       // Reference PC
    word_t       m_saved;    // Reference saved PC
    bit          m_except;   // Reference exception state
    int          errors;
    int          checks;
    int          tests;

    control_flow_top #(
        .RESET_ADDRESS (RESET_ADDRESS),
        .IRQ_ADDRESS   (IRQ_ADDRESS),
        .TRAP_ADDRESS  (TRAP_ADDRESS)
    ) control_flow_top_i (
        .clk     (clk),
        .reset   (reset),
        .enable  (enable),
        .irq     (irq),
        .instr   (instr),
        .xs1     (xs1),
        .xs2     (xs2),
        .pc      (pc),
        .pc_next (pc_next)
    );

    always #(PERIOD / 2) clk = ~clk;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic word_t random_bits(input int n);
        word_t r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[30:0], lfsr_state[0]};   // One step per bit
        end
        return r;
    endfunction

    function automatic bit branch_holds(input logic [2:0] f3, input word_t a, input word_t b);
        case (f3)
            F3_BEQ:  return a == b;
            F3_BNE:  return a != b;
            F3_BLT:  return $signed(a) < $signed(b);
            F3_BGE:  return $signed(a) >= $signed(b);
            F3_BLTU: return a < b;
            F3_BGEU: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    function automatic word_t word_align(input word_t x);
        return {x[31:2], 2'b00};
    endfunction

    function automatic instr_word_u make_alu();   // addi x1, x0, 1
        instr_word_u i;
        i = '0;
        i.i_fmt.opcode  = 7'b001_0011;
        i.i_fmt.rd      = 5'd1;
        i.i_fmt.imm11_0 = 12'd1;
        return i;
    endfunction

    function automatic instr_word_u make_branch(input logic [2:0] f3, input logic [12:0] off);
        instr_word_u i;
        i = '0;
        i.b_fmt.opcode  = OPC_BRANCH;
        i.b_fmt.funct3  = f3;
        i.b_fmt.rs1     = 5'd1;
        i.b_fmt.rs2     = 5'd2;
        i.b_fmt.imm12   = off[12];
        i.b_fmt.imm11   = off[11];
        i.b_fmt.imm10_5 = off[10:5];
        i.b_fmt.imm4_1  = off[4:1];
        return i;
    endfunction

    function automatic instr_word_u make_jal(input logic [20:0] off);
        instr_word_u i;
        i = '0;
        i.j_fmt.opcode   = OPC_JAL;
        i.j_fmt.rd       = 5'd1;
        i.j_fmt.imm20    = off[20];
        i.j_fmt.imm19_12 = off[19:12];
        i.j_fmt.imm11    = off[11];
        i.j_fmt.imm10_1  = off[10:1];
        return i;
    endfunction

    function automatic instr_word_u make_jalr(input logic [11:0] off);
        instr_word_u i;
        i = '0;
        i.i_fmt.opcode  = OPC_JALR;
        i.i_fmt.rd      = 5'd1;
        i.i_fmt.rs1     = 5'd2;
        i.i_fmt.imm11_0 = off;
        return i;
    endfunction

    function automatic instr_word_u make_word(input word_t w);
        instr_word_u i;
        i.raw = w;
        return i;
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        assert (got === exp) else begin
            $display("[ERROR] %0t: %s expected %h, got %h", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int start);
        tests++;
        $display("Test %s finished with %0d errors", name, errors - start);
    endtask

    // One cycle; normal is the target without IRQ or ecall
    task automatic step(input instr_word_u ins, input word_t a, input word_t b,
                        input bit irq_in, input bit en, input word_t normal);
        word_t exp_next;
        bit    accept;
        bit    trap;
        bit    mret;
        @(negedge clk);
        instr  = ins;
        xs1    = a;
        xs2    = b;
        irq    = irq_in;
        enable = en;
        trap   = (ins.raw == INSTR_ECALL);
        mret   = (ins.raw == INSTR_MRET);
        accept = irq_in && !m_except;
        if (accept) begin
            exp_next = IRQ_ADDRESS;
        end else if (trap) begin
            exp_next = TRAP_ADDRESS;
        end else begin
            exp_next = normal;
        end
        #5;
        check_word("pc_next", pc_next, exp_next);
        @(posedge clk);
        if (en) begin
            if (accept || trap) begin
                m_saved = normal;
            end
            if (mret) begin
                m_except = 1'b0;
            end else if (irq_in) begin
                m_except = 1'b1;
            end
            m_pc = exp_next;
        end
        #1;
        check_word("pc", pc, m_pc);
    endtask

    task automatic test_sequential();
        int start;
        start = errors;
        check_word("pc", pc, RESET_ADDRESS);
        for (int i = 0; i < 3; i++) begin
            step(make_alu(), '0, '0, 1'b0, 1'b1, m_pc + 32'd4);
        end
        for (int i = 0; i < 2; i++) begin
            step(make_alu(), '0, '0, 1'b0, 1'b0, m_pc + 32'd4);   // pc holds
        end
        step(make_alu(), '0, '0, 1'b0, 1'b1, m_pc + 32'd4);
        report_test("sequential", start);
    endtask

    // All eight funct3 codes, the two reserved ones included
    task automatic test_branches();
        int          start;
        logic [2:0]  f3;
        logic [12:0] off;
        word_t       a;
        word_t       b;
        word_t       x;
        word_t       y;
        word_t       w;
        word_t       normal;
        start = errors;
        for (int f = 0; f < 8; f++) begin
            f3 = 3'(f);
            a  = random_bits(32);
            b  = random_bits(32);
            for (int c = 0; c < 3; c++) begin
                w   = random_bits(12);
                off = {w[11:0], 1'b0};
                x   = (c == 1) ? b : a;
                y   = (c == 0) ? b : a;   // Third case has equal operands
                if (branch_holds(f3, x, y)) begin
                    normal = word_align(m_pc + {{19{off[12]}}, off});
                end else begin
                    normal = m_pc + 32'd4;
                end
                step(make_branch(f3, off), x, y, 1'b0, 1'b1, normal);
            end
        end
        report_test("branches", start);
    endtask

    task automatic test_jumps();
        int          start;
        logic [20:0] joff;
        word_t       a;
        word_t       w;
        start = errors;
        for (int i = 0; i < 3; i++) begin
            w    = random_bits(20);
            joff = {w[19:0], 1'b0};
            step(make_jal(joff), '0, '0, 1'b0, 1'b1,
                 word_align(m_pc + {{11{joff[20]}}, joff}));
        end
        for (int i = 0; i < 3; i++) begin
            a = random_bits(32) | 32'd1;   // Odd base
            w = random_bits(12);
            step(make_jalr(w[11:0]), a, '0, 1'b0, 1'b1,
                 word_align(a + {{20{w[11]}}, w[11:0]}));
        end
        report_test("jumps", start);
    endtask

    task automatic test_ecall_mret();
        int    start;
        word_t ret;
        start = errors;
        ret   = m_pc + 32'd4;
        step(make_word(INSTR_ECALL), '0, '0, 1'b0, 1'b1, m_pc + 32'd4);
        check_word("pc", pc, TRAP_ADDRESS);
        step(make_alu(), '0, '0, 1'b0, 1'b1, m_pc + 32'd4);
        step(make_word(INSTR_MRET), '0, '0, 1'b0, 1'b1, m_saved);
        check_word("pc", pc, ret);
        report_test("ecall_mret", start);
    endtask

    task automatic test_irq();
        int    start;
        word_t ret;
        start = errors;
        ret   = m_pc + 32'd4;
        step(make_alu(), '0, '0, 1'b1, 1'b1, m_pc + 32'd4);
        check_word("pc", pc, IRQ_ADDRESS);
        step(make_alu(), '0, '0, 1'b1, 1'b1, m_pc + 32'd4);   // Nested irq ignored
        check_word("pc", pc, IRQ_ADDRESS + 32'd4);
        step(make_word(INSTR_MRET), '0, '0, 1'b0, 1'b1, m_saved);
        check_word("pc", pc, ret);
        step(make_alu(), '0, '0, 1'b1, 1'b1, m_pc + 32'd4);
        check_word("pc", pc, IRQ_ADDRESS);
        step(make_word(INSTR_MRET), '0, '0, 1'b0, 1'b1, m_saved);
        report_test("irq", start);
    endtask

    task automatic test_irq_jump();
        int    start;
        word_t target;
        start  = errors;
        target = word_align(m_pc + 32'h100);
        step(make_jal(21'h00100), '0, '0, 1'b1, 1'b1, target);
        check_word("pc", pc, IRQ_ADDRESS);
        step(make_word(INSTR_MRET), '0, '0, 1'b0, 1'b1, m_saved);
        check_word("pc", pc, target);
        report_test("irq_jump", start);
    endtask

    initial begin
        reset      = 1'b1;
        enable     = 1'b0;
        irq        = 1'b0;
        instr      = '0;
        xs1        = '0;
        xs2        = '0;
        lfsr_state = 16'd38438;
        m_pc       = RESET_ADDRESS;
        m_saved    = '0;
        m_except   = 1'b0;
        errors     = 0;
        checks     = 0;
        tests      = 0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        test_sequential();
        test_branches();
        test_jumps();
        test_ecall_mret();
        test_irq();
        test_irq_jump();
        // Concurrent assertion failures count as errors too
        errors += control_flow_top_i.control_flow_assertions_i.failures;
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        #((TOTAL_CYCLES + MARGIN) * PERIOD);
        $display("Watchdog timeout, the tests did not finish in time");
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/control_flow_assertions.sv
// ----------------------------------------
// Control-flow assertions
// PC alignment, reset value and IRQ entry
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module control_flow_assertions #(
    parameter cf_pkg::word_t RESET_ADDRESS = 32'h0,
    parameter cf_pkg::word_t IRQ_ADDRESS   = 32'h0
) (
    input bit            clk,
    input bit            reset,
    input bit            enable,
    input bit            irq,
    input cf_pkg::word_t pc,
    input cf_pkg::word_t pc_next
);

    int failures = 0;   // Failed assertions so far

    pc_aligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
        else begin
            $error("pc is not word aligned");
            failures++;
        end

    pc_after_reset: assert property (@(posedge clk) reset |=> pc == RESET_ADDRESS)
        else begin
            $error("pc differs from the reset address after reset");
            failures++;
        end

    // Accepted interrupt lands on the handler one cycle later
    irq_entry: assert property (@(posedge clk) disable iff (reset)
        (enable && irq && pc_next == IRQ_ADDRESS) |=> pc == IRQ_ADDRESS)
        else begin
            $error("pc did not reach the IRQ handler");
            failures++;
        end

endmodule

bind control_flow_top control_flow_assertions #(
    .RESET_ADDRESS (RESET_ADDRESS),
    .IRQ_ADDRESS   (IRQ_ADDRESS)
) control_flow_assertions_i (
    .clk     (clk),
    .reset   (reset),
    .enable  (enable),
    .irq     (irq),
    .pc      (pc),
    .pc_next (pc_next)
);

`default_nettype wire

//--- verilog/control_flow_top.sv
// ----------------------------------------
// Control-flow top level
// Decoder feeding the PC sequencer
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module control_flow_top #(
    parameter cf_pkg::word_t RESET_ADDRESS = 32'h0000_0100,
    parameter cf_pkg::word_t IRQ_ADDRESS   = 32'h0000_0040,
    parameter cf_pkg::word_t TRAP_ADDRESS  = 32'h0000_0080
) (
    input  bit                  clk,
    input  bit                  reset,
    input  bit                  enable,
    input  bit                  irq,
    input  cf_pkg::instr_word_u instr,
    input  cf_pkg::word_t       xs1,
    input  cf_pkg::word_t       xs2,
    output cf_pkg::word_t       pc,
    output cf_pkg::word_t       pc_next
);

    import cf_pkg::*;

    bit         is_jump;
    bit         is_jalr;
    bit         is_branch;
    bit         is_trap;
    bit         is_mret;
    logic [2:0] funct3;
    word_t      imm;

    instr_decoder instr_decoder_i (
        .instr     (instr),
        .is_jump   (is_jump),
        .is_jalr   (is_jalr),
        .is_branch (is_branch),
        .is_trap   (is_trap),
        .is_mret   (is_mret),
        .funct3    (funct3),
        .imm       (imm)
    );

    pc_sequencer #(
        .RESET_ADDRESS (RESET_ADDRESS),
        .IRQ_ADDRESS   (IRQ_ADDRESS),
        .TRAP_ADDRESS  (TRAP_ADDRESS)
    ) pc_sequencer_i (
        .clk       (clk),
        .reset     (reset),
        .enable    (enable),
        .irq       (irq),
        .is_jump   (is_jump),
        .is_jalr   (is_jalr),
        .is_branch (is_branch),
        .is_trap   (is_trap),
        .is_mret   (is_mret),
        .funct3    (funct3),
        .imm       (imm),
        .xs1       (xs1),
        .xs2       (xs2),
        .pc        (pc),
        .pc_next   (pc_next)
    );

endmodule

`default_nettype wire

//--- verilog/pc_sequencer.sv
// ----------------------------------------
// PC sequencer
// PC register, increment and target adders
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module pc_sequencer #(
    parameter cf_pkg::word_t RESET_ADDRESS = 32'h0,
    parameter cf_pkg::word_t IRQ_ADDRESS   = 32'h0,
    parameter cf_pkg::word_t TRAP_ADDRESS  = 32'h0
) (
    input  bit            clk,
    input  bit            reset,
    input  bit            enable,
    input  bit            irq,
    input  bit            is_jump,
    input  bit            is_jalr,
    input  bit            is_branch,
    input  bit            is_trap,
    input  bit            is_mret,
    input  logic [2:0]    funct3,
    input  cf_pkg::word_t imm,
    input  cf_pkg::word_t xs1,
    input  cf_pkg::word_t xs2,
    output cf_pkg::word_t pc,
    output cf_pkg::word_t pc_next
);

    import cf_pkg::*;

    word_t pc_reg;
    word_t pc_incr;
    word_t target_base;
    word_t address;

    assign pc_incr     = pc_reg + 32'd4;
    assign target_base = is_jalr ? xs1 : pc_reg;   // jalr is register relative
    assign address     = target_base + imm;

    branch_unit #(
        .IRQ_ADDRESS  (IRQ_ADDRESS),
        .TRAP_ADDRESS (TRAP_ADDRESS)
    ) branch_unit_i (
        .clk       (clk),
        .reset     (reset),
        .enable    (enable),
        .irq       (irq),
        .is_jump   (is_jump),
        .is_branch (is_branch),
        .is_trap   (is_trap),
        .is_mret   (is_mret),
        .funct3    (funct3),
        .xs1       (xs1),
        .xs2       (xs2),
        .address   (address),
        .pc_incr   (pc_incr),
        .pc_next   (pc_next)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            pc_reg <= RESET_ADDRESS;
        end else if (enable) begin
            pc_reg <= pc_next;
        end
    end

    assign pc = pc_reg;

endmodule

`default_nettype wire

//--- verilog/instr_decoder.sv
// ----------------------------------------
// Instruction decoder
// Control flags, branch function and sign-extended immediate
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module instr_decoder (
    input  cf_pkg::instr_word_u instr,
    output bit                  is_jump,
    output bit                  is_jalr,
    output bit                  is_branch,
    output bit                  is_trap,
    output bit                  is_mret,
    output logic [2:0]          funct3,
    output cf_pkg::word_t       imm
);

    import cf_pkg::*;

    logic [6:0] opcode;
    bit         is_system;
    bit         is_jal;

    assign opcode = instr.raw[6:0];

    assign is_jal    = (opcode == OPC_JAL);
    assign is_jalr   = (opcode == OPC_JALR);
    assign is_branch = (opcode == OPC_BRANCH);
    assign is_jump   = is_jal || is_jalr;   // Both jump forms are unconditional

    // System instructions only count with their full encoding
    assign is_system = (opcode == OPC_SYSTEM);
    assign is_trap   = is_system && (instr.raw[31:7] == INSTR_ECALL[31:7]);
    assign is_mret   = is_system && (instr.raw[31:7] == INSTR_MRET[31:7]);

    assign funct3 = instr.b_fmt.funct3;   // Same bit position in every format

    // Immediate comes from the view that matches the opcode
    always_comb begin
        imm = '0;
        case (opcode)
            OPC_JALR: begin
                imm = {{20{instr.i_fmt.imm11_0[11]}}, instr.i_fmt.imm11_0};
            end
            OPC_BRANCH: begin
                imm = {{19{instr.b_fmt.imm12}},
                       instr.b_fmt.imm12,
                       instr.b_fmt.imm11,
                       instr.b_fmt.imm10_5,
                       instr.b_fmt.imm4_1,
                       1'b0};               // Branch offsets are in halfwords
            end
            OPC_JAL: begin
                imm = {{11{instr.j_fmt.imm20}},
                       instr.j_fmt.imm20,
                       instr.j_fmt.imm19_12,
                       instr.j_fmt.imm11,
                       instr.j_fmt.imm10_1,
                       1'b0};
            end
            default: begin
                imm = '0;                   // No target for other opcodes
            end
        endcase
    end

endmodule

`default_nettype wire

//--- branch_unit/branch_unit.sv
// ----------------------------------------
// Branch unit
// Next-PC selection with IRQ, ecall and mret handling
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module branch_unit #(
    parameter cf_pkg::word_t IRQ_ADDRESS  = 32'h0,
    parameter cf_pkg::word_t TRAP_ADDRESS = 32'h0
) (
    input  bit            clk,
    input  bit            reset,
    input  bit            enable,
    input  bit            irq,
    input  bit            is_jump,
    input  bit            is_branch,
    input  bit            is_trap,
    input  bit            is_mret,
    input  logic [2:0]    funct3,
    input  cf_pkg::word_t xs1,
    input  cf_pkg::word_t xs2,
    input  cf_pkg::word_t address,
    input  cf_pkg::word_t pc_incr,
    output cf_pkg::word_t pc_next
);

    import cf_pkg::*;

    bit    taken;
    bit    accept_irq;
    bit    except_state;   // Set while an interrupt is being serviced
    word_t pc_target;      // Where execution goes without IRQ or trap
    word_t saved_pc;       // Return address for mret

    comparator comparator_i (
        .funct3 (funct3),
        .a      (xs1),
        .b      (xs2),
        .taken  (taken)
    );

    // Jump and branch targets are forced to a word boundary
    always_comb begin
        if (is_mret) begin
            pc_target = saved_pc;
        end else if (is_jump || (is_branch && taken)) begin
            pc_target = {address[31:2], 2'b00};
        end else begin
            pc_target = pc_incr;
        end
    end

    assign accept_irq = irq && !except_state;   // No nesting

    always_ff @(posedge clk) begin
        if (reset) begin
            except_state <= 1'b0;
        end else if (enable) begin
            if (is_mret) begin
                except_state <= 1'b0;
            end else if (irq) begin
                except_state <= 1'b1;
            end
        end
    end

    // Return address is the target the interrupted or trapping cycle would take
    always_ff @(posedge clk) begin
        if (reset) begin
            saved_pc <= '0;
        end else if (enable && (accept_irq || is_trap)) begin
            saved_pc <= pc_target;
        end
    end

    always_comb begin
        if (accept_irq) begin
            pc_next = IRQ_ADDRESS;
        end else if (is_trap) begin
            pc_next = TRAP_ADDRESS;
        end else begin
            pc_next = pc_target;
        end
    end

endmodule

`default_nettype wire

//--- branch_unit/comparator.sv
// ----------------------------------------
// Branch comparator
// Evaluates the six RV32I branch conditions
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module comparator (
    input  logic [2:0]    funct3,
    input  cf_pkg::word_t a,
    input  cf_pkg::word_t b,
    output bit            taken
);

    import cf_pkg::*;

    bit equal;
    bit less_signed;
    bit less_unsigned;

    assign equal         = (a == b);
    assign less_signed   = ($signed(a) < $signed(b));
    assign less_unsigned = (a < b);

    always_comb begin
        case (funct3)
            F3_BEQ:  taken = equal;
            F3_BNE:  taken = !equal;
            F3_BLT:  taken = less_signed;
            F3_BGE:  taken = !less_signed;
            F3_BLTU: taken = less_unsigned;
            F3_BGEU: taken = !less_unsigned;
            default: taken = 1'b0;          // Reserved encodings never branch
        endcase
    end

endmodule

`default_nettype wire

//--- common/cf_pkg.sv
// ----------------------------------------
// Control-flow package
// Word type, instruction views and the RV32I encodings used by the decoder
// ----------------------------------------
`default_nettype none

package cf_pkg;

    typedef logic [31:0] word_t;   // Data or address word

    // One instruction word seen in the formats the control-flow path decodes
    typedef union packed {
        word_t raw;
        struct packed {
            logic [11:0] imm11_0;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i_fmt;
        struct packed {
            logic        imm12;
            logic [5:0]  imm10_5;
            logic [4:0]  rs2;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [3:0]  imm4_1;
            logic        imm11;
            logic [6:0]  opcode;
        } b_fmt;
        struct packed {
            logic        imm20;
            logic [9:0]  imm10_1;
            logic        imm11;
            logic [7:0]  imm19_12;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } j_fmt;
    } instr_word_u;

    localparam logic [6:0] OPC_JAL    = 7'b110_1111;
    localparam logic [6:0] OPC_JALR   = 7'b110_0111;
    localparam logic [6:0] OPC_BRANCH = 7'b110_0011;
    localparam logic [6:0] OPC_SYSTEM = 7'b111_0011;

    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam word_t INSTR_ECALL = 32'h0000_0073;
    localparam word_t INSTR_MRET  = 32'h3020_0073;

endpackage

`default_nettype wire
